//--- build.f
+incdir+rtl
rtl/cachePkg.sv
rtl/sramArray.sv
rtl/cacheCtrl.sv
rtl/tagLookup.sv
rtl/lineRefill.sv
rtl/dataSelect.sv
rtl/cacheTop.sv
dv/memResponder.sv
dv/cacheTb.sv

//--- dv/cacheTb.sv
`timescale 1ns/1ps
`include "cache_cfg.svh"

module cacheTb import cachePkg::*; ();

  localparam logic [`WORD_WIDTH-1:0] MEM_PATTERN = 64'h5a5a_0f0f_c3c3_9669;
  localparam int NUM_RANDOM = 388;
  // 400 requests of at most 4 beats of 8 cycles plus compare and respond
  localparam int CYCLE_LIMIT = 400 * 36 + 500;

  typedef struct {
    logic [`WORD_WIDTH-1:0] word;
    logic                   hit;
    int                     acceptCycle;
  } expT;

  logic                   clk = 1'b0;
  logic                   rst_n;
  logic                   valid_i;
  logic [`ADDR_WIDTH-1:0] addr_i;
  logic                   addrOk_o;
  logic                   dataOk_o;
  logic [`WORD_WIDTH-1:0] rdData_o;
  logic                   memReq_o;
  logic [`ADDR_WIDTH-1:0] memAddr_o;
  logic                   memAck_i;
  logic [`WORD_WIDTH-1:0] memData_i;
  int                     beatCount;
  int                     errors, cycle, acceptCount, missCount, beatIdx, lastAck;
  string                  testName = "reset";
  expT                    expQ [$];
  logic [`ADDR_WIDTH-1:0] missQ [$];
  // two-way tag and lru model where lru points at the next victim
  tagT                    mTag [2][`SET_COUNT];
  logic                   mValid [2][`SET_COUNT];
  logic                   mLru [`SET_COUNT];

  cacheTop dut0 (.*);

  memResponder #(.PATTERN(MEM_PATTERN)) mem0 (
    .clk, .memReq_i (memReq_o), .memAddr_i (memAddr_o),
    .memAck_o (memAck_i), .memData_o (memData_i), .beatCount_o (beatCount)
  );

  always #50 clk = ~clk;

  function automatic logic [`ADDR_WIDTH-1:0] makeAddr(tagT t, indexT s, wordSelT w);
    return {t, s, w, {`BYTE_BITS{1'b0}}};
  endfunction

  function automatic logic [`WORD_WIDTH-1:0] memWord(logic [`ADDR_WIDTH-1:0] a);
    logic [`WORD_WIDTH-1:0] wordAddr;
    wordAddr = a >> `BYTE_BITS;
    return wordAddr ^ MEM_PATTERN;
  endfunction

  task automatic predictAccess(input logic [`ADDR_WIDTH-1:0] a, output logic isHit);
    tagT   t;
    indexT s;
    logic  w;
    t     = a[`ADDR_WIDTH-1 -: `TAG_BITS];
    s     = a[`OFFSET_BITS +: `INDEX_BITS];
    isHit = 1'b0;
    for (int k = 0; k < 2; k++) begin
      if (mValid[k][s] && mTag[k][s] == t) begin
        isHit = 1'b1;
        w     = k[0];
      end
    end
    if (!isHit) begin
      w            = mLru[s];
      mValid[w][s] = 1'b1;
      mTag[w][s]   = t;
    end
    mLru[s] = ~w;
  endtask

  task automatic issue(input logic [`ADDR_WIDTH-1:0] a);
    valid_i <= 1'b1;
    addr_i  <= a;
    @(posedge clk);
    while (!addrOk_o) @(posedge clk);
    valid_i <= 1'b0;
  endtask

  task automatic drain();
    @(negedge clk);
    while (expQ.size() != 0) @(negedge clk);
    @(posedge clk);
  endtask

  // response data, latency and refill beats against the model
  always @(posedge clk) begin
    expT                    e;
    int                     dueCycle;
    logic [`ADDR_WIDTH-1:0] beatAddr;
    if (rst_n) begin
      cycle++;
      if (dataOk_o) begin
        if (expQ.size() == 0) begin
          errors++;
          $display("Error: response returned with no request outstanding");
        end else begin
          e        = expQ.pop_front();
          dueCycle = e.hit ? e.acceptCycle + 1 : lastAck + 2;
          assert (rdData_o === e.word) else begin
            errors++;
            $display("Fail %s expected %h actual %h", testName, e.word, rdData_o);
          end
          assert (cycle == dueCycle) else begin
            errors++;
            $display("Fail %s response cycle expected %0d actual %0d", testName, dueCycle, cycle);
          end
        end
      end
      if (memReq_o && memAck_i) begin
        if (missQ.size() == 0) begin
          errors++;
          $display("Error: memory beat requested while no miss was outstanding");
        end else begin
          beatAddr = missQ[0] + beatIdx * (`WORD_WIDTH / 8);
          assert (memAddr_o === beatAddr) else begin
            errors++;
            $display("Fail %s beat address expected %h actual %h", testName, beatAddr, memAddr_o);
          end
          lastAck = cycle;
          beatIdx++;
          if (beatIdx == `LINE_WORDS) begin
            beatIdx = 0;
            missQ.delete(0);
          end
        end
      end
      if (valid_i && addrOk_o) begin
        predictAccess(addr_i, e.hit);
        e.word        = memWord(addr_i);
        e.acceptCycle = cycle;
        expQ.push_back(e);
        acceptCount++;
        if (!e.hit) begin
          missCount++;
          missQ.push_back({addr_i[`ADDR_WIDTH-1:`OFFSET_BITS], {`OFFSET_BITS{1'b0}}});
        end
      end
    end
  end

  idleAfterReset: assert property (@(posedge clk) disable iff (!rst_n)
      (acceptCount == 0) |-> (addrOk_o && !dataOk_o && !memReq_o))
    else begin
      errors++;
      $display("Error: cache ports not idle after reset");
    end

  reqAfterAckLow: assert property (@(posedge clk) disable iff (!rst_n)
      $rose(memReq_o) |-> !$past(memAck_i))
    else begin
      errors++;
      $display("Error: memory request raised while ack still high");
    end

  reqDropsOnAck: assert property (@(posedge clk) disable iff (!rst_n)
      (memReq_o && memAck_i) |=> !memReq_o)
    else begin
      errors++;
      $display("Error: memory request held after ack was seen");
    end

  addrStable: assert property (@(posedge clk) disable iff (!rst_n)
      (memReq_o && $past(memReq_o)) |-> $stable(memAddr_o))
    else begin
      errors++;
      $display("Error: memory address changed during a request");
    end

  portClosedOnMiss: assert property (@(posedge clk) disable iff (!rst_n)
      memReq_o |-> !addrOk_o)
    else begin
      errors++;
      $display("Error: new request accepted during a refill");
    end

  // run limit
  always @(negedge clk) begin
    if (cycle > CYCLE_LIMIT) begin
      $display("Error: timeout, run exceeded %0d cycles", CYCLE_LIMIT);
      $display("Simulation failed");
      $finish;
    end
  end

  initial begin
    void'($urandom(76199));
    rst_n   = 1'b0;
    valid_i = 1'b0;
    addr_i  = '0;
    foreach (mValid[k, s]) mValid[k][s] = 1'b0;
    foreach (mLru[s]) mLru[s] = 1'b0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    repeat (3) @(posedge clk);

    testName = "coldMiss";
    issue(makeAddr(21'h1, 6'd5, 2'd2));
    drain();

    // whole line back to back as hits
    testName = "hitStream";
    for (int w = 0; w < 4; w++) issue(makeAddr(21'h1, 6'd5, wordSelT'(w)));
    drain();

    // tags 2 and 3 share set 9 and tag 4 then evicts the older one
    testName = "eviction";
    issue(makeAddr(21'h2, 6'd9, 2'd0));
    issue(makeAddr(21'h3, 6'd9, 2'd1));
    issue(makeAddr(21'h2, 6'd9, 2'd2));
    issue(makeAddr(21'h3, 6'd9, 2'd3));
    issue(makeAddr(21'h4, 6'd9, 2'd0));
    issue(makeAddr(21'h3, 6'd9, 2'd1));
    issue(makeAddr(21'h2, 6'd9, 2'd2));
    drain();

    testName = "random";
    for (int i = 0; i < NUM_RANDOM; i++) begin
      issue(makeAddr(tagT'($urandom_range(3, 0)), indexT'($urandom_range(3, 0)),
                     wordSelT'($urandom_range(3, 0))));
      if ($urandom_range(3, 0) == 0) @(posedge clk);
    end
    drain();

    assert (beatCount == missCount * `LINE_WORDS) else begin
      errors++;
      $display("Fail refillCount expected %0d actual %0d", missCount * `LINE_WORDS, beatCount);
    end
    $display("Done: %0d errors, %0d requests, %0d refills", errors, acceptCount, missCount);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- dv/memResponder.sv
`timescale 1ns/1ps
`include "cache_cfg.svh"

module memResponder #(
  parameter logic [`WORD_WIDTH-1:0] PATTERN = '0
) (
  input  logic                   clk,
  input  logic                   memReq_i,
  input  logic [`ADDR_WIDTH-1:0] memAddr_i,
  output logic                   memAck_o,
  output logic [`WORD_WIDTH-1:0] memData_o,
  output int                     beatCount_o
);

  int                     delay;
  logic [`WORD_WIDTH-1:0] wordAddr;

  // one four-phase handshake per beat with ack after 0 to 3 idle cycles
  initial begin
    memAck_o    = 1'b0;
    memData_o   = '0;
    beatCount_o = 0;
    forever begin
      @(posedge clk);
      if (memReq_i && !memAck_o) begin
        delay = $urandom_range(3, 0);
        repeat (delay) @(posedge clk);
        wordAddr = memAddr_i >> `BYTE_BITS;
        memData_o   <= wordAddr ^ PATTERN;
        memAck_o    <= 1'b1;
        beatCount_o <= beatCount_o + 1;
        // hold ack until the request drops
        do @(posedge clk); while (memReq_i);
        memAck_o <= 1'b0;
      end
    end
  end

endmodule

//--- rtl/cacheCtrl.sv
`timescale 1ns/1ps
`include "cache_cfg.svh"

module cacheCtrl import cachePkg::*; (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   valid_i,
  input  logic [`ADDR_WIDTH-1:0] addr_i,
  input  logic                   hit_i,
  input  logic                   refillDone_i,
  output logic                   addrOk_o,
  output logic                   dataOk_o,
  output logic                   lookupEn_o,
  output indexT                  index_o,
  output tagT                    tag_o,
  output wordSelT                wordSel_o,
  output logic                   refillStart_o,
  output logic                   fillWrite_o,
  output logic                   fromRefill_o
);

  ctrlStateT state;
  ctrlStateT nextState;
  logic      accept;

  // a hit frees the port for the next request in the same cycle
  assign addrOk_o = (state == stIdle) || ((state == stCompare) && hit_i);
  assign accept   = valid_i && addrOk_o;

  // array reads launch on acceptance
  assign lookupEn_o = accept;

  assign dataOk_o      = ((state == stCompare) && hit_i) || (state == stRespond);
  assign refillStart_o = (state == stCompare) && !hit_i;
  assign fillWrite_o   = (state == stRespond);
  assign fromRefill_o  = (state == stRespond);

  always_comb begin
    nextState = state;
    case (state)
      stIdle: begin
        if (accept) begin
          nextState = stCompare;
        end
      end
      stCompare: begin
        if (!hit_i) begin
          nextState = stRefill;
        end else if (!accept) begin
          nextState = stIdle;
        end
      end
      stRefill: begin
        if (refillDone_i) begin
          nextState = stRespond;
        end
      end
      stRespond: begin
        nextState = stIdle;
      end
      default: begin
        nextState = stIdle;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= stIdle;
    end else begin
      state <= nextState;
    end
  end

  // request fields held until the next acceptance
  always_ff @(posedge clk) begin
    if (accept) begin
      wordSel_o <= addr_i[`BYTE_BITS +: `WORD_SEL_BITS];
      index_o   <= addr_i[`OFFSET_BITS +: `INDEX_BITS];
      tag_o     <= addr_i[`ADDR_WIDTH-1 -: `TAG_BITS];
    end
  end

endmodule

//--- rtl/cachePkg.sv
`include "cache_cfg.svh"

package cachePkg;

  // address fields
  typedef logic [`TAG_BITS-1:0]      tagT;
  typedef logic [`INDEX_BITS-1:0]    indexT;
  typedef logic [`WORD_SEL_BITS-1:0] wordSelT;

  // one tag array entry
  typedef struct packed {
    logic valid;
    tagT  tag;
  } tagEntryT;

  // word 0 sits at the line base
  typedef logic [`LINE_WORDS-1:0][`WORD_WIDTH-1:0] lineT;

  typedef enum logic [1:0] {
    stIdle,
    stCompare,
    stRefill,
    stRespond
  } ctrlStateT;

endpackage

//--- rtl/cacheTop.sv
`timescale 1ns/1ps
`include "cache_cfg.svh"

module cacheTop import cachePkg::*; (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   valid_i,
  input  logic [`ADDR_WIDTH-1:0] addr_i,
  output logic                   addrOk_o,
  output logic                   dataOk_o,
  output logic [`WORD_WIDTH-1:0] rdData_o,
  output logic                   memReq_o,
  output logic [`ADDR_WIDTH-1:0] memAddr_o,
  input  logic                   memAck_i,
  input  logic [`WORD_WIDTH-1:0] memData_i
);

  logic    lookupEn;
  indexT   lookupIndex;
  indexT   index;
  tagT     tag;
  wordSelT wordSel;
  logic    refillStart;
  logic    fillWrite;
  logic    fromRefill;
  logic    hit;
  logic    hitWay;
  logic    victimWay;
  logic    refillDone;
  lineT    fillLine;

  // set index of the incoming request for the array reads
  assign lookupIndex = addr_i[`OFFSET_BITS +: `INDEX_BITS];

  cacheCtrl ctrl0 (
    .clk, .rst_n, .valid_i, .addr_i, .addrOk_o, .dataOk_o,
    .hit_i (hit), .refillDone_i (refillDone), .lookupEn_o (lookupEn),
    .index_o (index), .tag_o (tag), .wordSel_o (wordSel),
    .refillStart_o (refillStart), .fillWrite_o (fillWrite), .fromRefill_o (fromRefill)
  );

  tagLookup tags0 (
    .clk, .rst_n, .lookupEn_i (lookupEn), .lookupIndex_i (lookupIndex),
    .index_i (index), .tag_i (tag), .fillWrite_i (fillWrite),
    .hit_o (hit), .hitWay_o (hitWay), .victimWay_o (victimWay)
  );

  lineRefill refill0 (
    .clk, .rst_n, .refillStart_i (refillStart), .tag_i (tag), .index_i (index),
    .memAck_i, .memData_i, .memReq_o, .memAddr_o,
    .refillDone_o (refillDone), .line_o (fillLine)
  );

  dataSelect data0 (
    .clk, .lookupEn_i (lookupEn), .lookupIndex_i (lookupIndex), .index_i (index),
    .wordSel_i (wordSel), .hitWay_i (hitWay), .victimWay_i (victimWay),
    .fillWrite_i (fillWrite), .fillLine_i (fillLine), .fromRefill_i (fromRefill),
    .rdData_o
  );

endmodule

//--- rtl/cache_cfg.svh
`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

// base sizes
`define ADDR_WIDTH    32
`define WORD_WIDTH    64
`define LINE_WORDS    4
`define SET_COUNT     64

// derived address field widths
`define BYTE_BITS     $clog2(`WORD_WIDTH / 8)
`define WORD_SEL_BITS $clog2(`LINE_WORDS)
`define OFFSET_BITS   (`WORD_SEL_BITS + `BYTE_BITS)
`define INDEX_BITS    $clog2(`SET_COUNT)
`define TAG_BITS      (`ADDR_WIDTH - `INDEX_BITS - `OFFSET_BITS)

`endif

//--- rtl/dataSelect.sv
`timescale 1ns/1ps
`include "cache_cfg.svh"

module dataSelect import cachePkg::*; (
  input  logic                   clk,
  input  logic                   lookupEn_i,
  input  indexT                  lookupIndex_i,
  input  indexT                  index_i,
  input  wordSelT                wordSel_i,
  input  logic                   hitWay_i,
  input  logic                   victimWay_i,
  input  logic                   fillWrite_i,
  input  lineT                   fillLine_i,
  input  logic                   fromRefill_i,
  output logic [`WORD_WIDTH-1:0] rdData_o
);

  indexT arrAddr;
  lineT  wayLine [2];
  lineT  selLine;

  assign arrAddr = fillWrite_i ? index_i : lookupIndex_i;

  for (genvar w = 0; w < 2; w++) begin : gWay
    logic wayWe;

    // refilled line lands in the victim way only
    assign wayWe = fillWrite_i && (victimWay_i == 1'(w));

    sramArray #(
      .entryT (lineT),
      .DEPTH  (`SET_COUNT)
    ) dataArr (
      .clk     (clk),
      .en_i    (lookupEn_i || wayWe),
      .we_i    (wayWe),
      .addr_i  (arrAddr),
      .wdata_i (fillLine_i),
      .rdata_o (wayLine[w])
    );
  end

  // a miss answers straight from the refill buffer
  assign selLine  = fromRefill_i ? fillLine_i : wayLine[hitWay_i];
  assign rdData_o = selLine[wordSel_i];

endmodule

//--- rtl/lineRefill.sv
`timescale 1ns/1ps
`include "cache_cfg.svh"

module lineRefill import cachePkg::*; (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   refillStart_i,
  input  tagT                    tag_i,
  input  indexT                  index_i,
  input  logic                   memAck_i,
  input  logic [`WORD_WIDTH-1:0] memData_i,
  output logic                   memReq_o,
  output logic [`ADDR_WIDTH-1:0] memAddr_o,
  output logic                   refillDone_o,
  output lineT                   line_o
);

  logic    busy;
  wordSelT beat;
  logic    ackSeen;

  // one word per handshake starting from the line base
  assign memAddr_o = {tag_i, index_i, beat, {`BYTE_BITS{1'b0}}};
  assign ackSeen   = memReq_o && memAck_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy         <= 1'b0;
      beat         <= '0;
      memReq_o     <= 1'b0;
      refillDone_o <= 1'b0;
    end else begin
      refillDone_o <= 1'b0;
      if (refillStart_i) begin
        busy <= 1'b1;
        beat <= '0;
      end else if (ackSeen) begin
        // drop req, then wait for ack low before the next beat
        memReq_o <= 1'b0;
        if (beat == wordSelT'(`LINE_WORDS - 1)) begin
          busy         <= 1'b0;
          refillDone_o <= 1'b1;
        end else begin
          beat <= beat + 1'b1;
        end
      end else if (busy && !memReq_o && !memAck_i) begin
        memReq_o <= 1'b1;
      end
    end
  end

  // line buffer
  always_ff @(posedge clk) begin
    if (ackSeen) begin
      line_o[beat] <= memData_i;
    end
  end

endmodule

//--- rtl/sramArray.sv
`timescale 1ns/1ps

module sramArray #(
  parameter type entryT = logic [31:0],
  parameter int  DEPTH  = 64
) (
  input  logic                     clk,
  input  logic                     en_i,
  input  logic                     we_i,
  input  logic [$clog2(DEPTH)-1:0] addr_i,
  input  entryT                    wdata_i,
  output entryT                    rdata_o
);

  entryT mem [DEPTH];

  // single port where a write wins over a read
  // read data holds until the next enabled read
  always_ff @(posedge clk) begin
    if (en_i) begin
      if (we_i) begin
        mem[addr_i] <= wdata_i;
      end else begin
        rdata_o <= mem[addr_i];
      end
    end
  end

endmodule

//--- rtl/tagLookup.sv
`timescale 1ns/1ps
`include "cache_cfg.svh"

module tagLookup import cachePkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  lookupEn_i,
  input  indexT lookupIndex_i,
  input  indexT index_i,
  input  tagT   tag_i,
  input  logic  fillWrite_i,
  output logic  hit_o,
  output logic  hitWay_o,
  output logic  victimWay_o
);

  logic [1:0][`SET_COUNT-1:0] validBits;
  // per set pointer to the way to replace next
  logic [`SET_COUNT-1:0]      lruBits;
  logic                       lookupQ;
  logic [1:0]                 wayHit;
  indexT                      arrAddr;
  tagEntryT                   fillEntry;
  tagEntryT                   rdEntry [2];

  // fill uses the latched set, lookups the raw one
  assign arrAddr   = fillWrite_i ? index_i : lookupIndex_i;
  assign fillEntry = '{valid: 1'b1, tag: tag_i};

  for (genvar w = 0; w < 2; w++) begin : gWay
    logic wayWe;

    assign wayWe = fillWrite_i && (victimWay_o == 1'(w));

    sramArray #(
      .entryT (tagEntryT),
      .DEPTH  (`SET_COUNT)
    ) tagArr (
      .clk     (clk),
      .en_i    (lookupEn_i || wayWe),
      .we_i    (wayWe),
      .addr_i  (arrAddr),
      .wdata_i (fillEntry),
      .rdata_o (rdEntry[w])
    );

    assign wayHit[w] = validBits[w][index_i] && rdEntry[w].valid &&
                       (rdEntry[w].tag == tag_i);
  end

  assign hit_o       = |wayHit;
  assign hitWay_o    = wayHit[1];
  assign victimWay_o = lruBits[index_i];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      validBits <= '0;
      lruBits   <= '0;
      lookupQ   <= 1'b0;
    end else begin
      // high exactly in the compare cycle
      lookupQ <= lookupEn_i;
      if (fillWrite_i) begin
        validBits[victimWay_o][index_i] <= 1'b1;
        lruBits[index_i]                <= ~victimWay_o;
      end else if (lookupQ && hit_o) begin
        lruBits[index_i] <= ~hitWay_o;
      end
    end
  end

endmodule
